// ==== include/iq_cfg.svh ====
// Integer issue queue configuration.
// Queue depth, tag width and wakeup port count shared across the design.
`ifndef IQ_CFG_SVH
`define IQ_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// queue geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// number of entries, kept in age order with the oldest in slot 0.
`define IQ_DEPTH 12

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tags and wakeup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// physical register and ROB tags share one width.
`define IQ_TAG_W 6

// one broadcast per execution unit.
`define IQ_NUM_WK 3

`endif

// ==== verilog/iq_pkg.sv ====
// Integer issue queue types.
// Entry, wakeup and issue payload layouts plus the shared tag match.
`default_nettype none

package iq_pkg;

    `include "iq_cfg.svh"

    typedef logic [`IQ_TAG_W-1:0] tag_t;

    typedef struct packed {
        tag_t rs1;
        tag_t rs2;
        tag_t rob;
        logic branch;       // entry may only issue on ALU 0.
    } iq_entry_t;

    typedef struct packed {
        logic vld;
        tag_t tag;
    } wakeup_t;

    typedef wakeup_t [`IQ_NUM_WK-1:0] wakeup_vec_t;

    typedef struct packed {
        tag_t rs2;
        tag_t rs1;
        tag_t rob;
    } issue_t;

    // true when any valid broadcast carries the given tag.
    function automatic logic wk_match(input wakeup_vec_t wk, input tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < `IQ_NUM_WK; k++) begin
            hit = hit | (wk[k].vld & (wk[k].tag == tag));
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/iq_if.sv ====
// Issue queue internal interfaces.
// Allocation from dispatch into the queue, and the ready/grant path to select.
`timescale 1ns/10ps
`default_nettype none

`include "iq_cfg.svh"

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dispatch to queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface iq_alloc_if;
    import iq_pkg::*;

    logic      alloc_vld;
    iq_entry_t alloc_entry;
    logic      alloc_rs1_av;   // rs1 needs no further wakeup.
    logic      alloc_rs2_av;
    logic      busy;           // every slot is occupied.

    modport producer (
        output alloc_vld, alloc_entry, alloc_rs1_av, alloc_rs2_av
    );

    modport queue (
        input  alloc_vld, alloc_entry, alloc_rs1_av, alloc_rs2_av,
        output busy
    );
endinterface

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// queue to select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface iq_select_if;
    import iq_pkg::*;

    logic [`IQ_DEPTH-1:0]      rdy_vec;
    logic [`IQ_DEPTH-1:0]      branch_vec;
    iq_entry_t [`IQ_DEPTH-1:0] entries;
    logic [`IQ_DEPTH-1:0]      grant0;     // one-hot, ALU 0.
    logic [`IQ_DEPTH-1:0]      grant1;     // one-hot, ALU 1.

    modport queue (
        output rdy_vec, branch_vec, entries,
        input  grant0, grant1
    );

    modport select (
        input  rdy_vec, branch_vec, entries,
        output grant0, grant1
    );
endinterface

`default_nettype wire

// ==== verilog/iq_dispatch.sv ====
// Issue queue dispatch stage.
// Packs the incoming instruction and resolves its sources against live wakeups.
`timescale 1ns/10ps
`default_nettype none

module iq_dispatch (
    input  wire logic                disp_vld_i,
    input  wire logic                disp_branch_i,
    input  wire iq_pkg::tag_t        disp_rs1_i,
    input  wire iq_pkg::tag_t        disp_rs2_i,
    input  wire iq_pkg::tag_t        disp_rob_i,
    input  wire logic                disp_rs1_vld_i,
    input  wire logic                disp_rs2_vld_i,
    input  wire logic                disp_rs1_rdy_i,
    input  wire logic                disp_rs2_rdy_i,
    input  wire iq_pkg::wakeup_vec_t wk_i,
    iq_alloc_if.producer             alloc
);
    import iq_pkg::*;

    logic rs1_hit;
    logic rs2_hit;

    // a producer finishing this very cycle must not be missed.
    assign rs1_hit = wk_match(wk_i, disp_rs1_i);
    assign rs2_hit = wk_match(wk_i, disp_rs2_i);

    // the queue decides acceptance.
    assign alloc.alloc_vld = disp_vld_i;

    assign alloc.alloc_entry = '{
        rs1:    disp_rs1_i,
        rs2:    disp_rs2_i,
        rob:    disp_rob_i,
        branch: disp_branch_i
    };

    // an unused source counts as available.
    assign alloc.alloc_rs1_av = !disp_rs1_vld_i | disp_rs1_rdy_i | rs1_hit;
    assign alloc.alloc_rs2_av = !disp_rs2_vld_i | disp_rs2_rdy_i | rs2_hit;

endmodule

`default_nettype wire

// ==== verilog/iq_entries.sv ====
// Issue queue entry array.
// Collapsing age-ordered storage with per-entry wakeup match and flush.
`timescale 1ns/10ps
`default_nettype none

`include "iq_cfg.svh"

module iq_entries (
    input  wire logic                cpu_clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                flush_i,
    input  wire iq_pkg::wakeup_vec_t wk_i,
    iq_alloc_if.queue                alloc,
    iq_select_if.queue               sel
);
    import iq_pkg::*;

    localparam int DEPTH = `IQ_DEPTH;

    logic [DEPTH-1:0]      vld_q;
    logic [DEPTH-1:0]      av1_q;
    logic [DEPTH-1:0]      av2_q;
    iq_entry_t [DEPTH-1:0] ent_q;

    // survivors of this cycle, padded with two empty slots above the top.
    logic [DEPTH+1:0]      vld_x;
    logic [DEPTH+1:0]      av1_x;
    logic [DEPTH+1:0]      av2_x;
    iq_entry_t [DEPTH+1:0] ent_x;
    logic [DEPTH-1:0]      one_hole;
    logic [DEPTH:0]        two_holes;

    logic [DEPTH-1:0]      vld_n;
    logic [DEPTH-1:0]      av1_n;
    logic [DEPTH-1:0]      av2_n;
    iq_entry_t [DEPTH-1:0] ent_n;
    logic                  accept;

    assign alloc.busy = &vld_q;
    assign accept     = alloc.alloc_vld & !alloc.busy & !flush_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wakeup, grant removal, collapse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        int src;
        vld_x = '0;
        av1_x = '0;
        av2_x = '0;
        ent_x = '0;
        for (int i = 0; i < DEPTH; i++) begin
            vld_x[i] = vld_q[i] & !sel.grant0[i] & !sel.grant1[i] & !flush_i;
            av1_x[i] = av1_q[i] | wk_match(wk_i, ent_q[i].rs1);
            av2_x[i] = av2_q[i] | wk_match(wk_i, ent_q[i].rs2);
            ent_x[i] = ent_q[i];
        end

        // saturating hole count below and including each slot.
        one_hole[0]  = !vld_x[0];
        two_holes[0] = 1'b0;
        for (int i = 1; i < DEPTH; i++) begin
            one_hole[i] = one_hole[i-1] | !vld_x[i];
        end
        for (int i = 1; i <= DEPTH; i++) begin
            two_holes[i] = two_holes[i-1] | (one_hole[i-1] & !vld_x[i]);
        end

        for (int i = 0; i < DEPTH; i++) begin
            if (two_holes[i+1]) begin
                src = i + 2;
            end else if (one_hole[i]) begin
                src = i + 1;
            end else begin
                src = i;
            end
            vld_n[i] = vld_x[src];
            av1_n[i] = av1_x[src];
            av2_n[i] = av2_x[src];
            ent_n[i] = ent_x[src];
        end

        // the collapsed array is contiguous, so the new entry lands just above it.
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (accept && !vld_n[i] && (i == 0 || vld_n[i-1])) begin
                vld_n[i] = 1'b1;
                av1_n[i] = alloc.alloc_rs1_av;
                av2_n[i] = alloc.alloc_rs2_av;
                ent_n[i] = alloc.alloc_entry;
            end
        end
    end

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
            av1_q <= '0;
            av2_q <= '0;
        end else begin
            vld_q <= vld_n;
            av1_q <= av1_n;
            av2_q <= av2_n;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        ent_q <= ent_n;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // select side view
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign sel.rdy_vec = vld_q & av1_q & av2_q & {DEPTH{!flush_i}};
    assign sel.entries = ent_q;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            sel.branch_vec[i] = ent_q[i].branch;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/iq_select.sv ====
// Issue queue select stage.
// Two-way oldest-first pick with registered ALU 0 and ALU 1 issue ports.
`timescale 1ns/10ps
`default_nettype none

`include "iq_cfg.svh"

module iq_select (
    input  wire logic      cpu_clk_i,
    input  wire logic      rst_n_i,
    input  wire logic      flush_i,
    iq_select_if.select    sel,
    output logic           alu0_vld_o,
    output iq_pkg::issue_t alu0_data_o,
    output logic           alu1_vld_o,
    output iq_pkg::issue_t alu1_data_o
);
    import iq_pkg::*;

    localparam int DEPTH = `IQ_DEPTH;

    logic [DEPTH-1:0] gnt0;
    logic [DEPTH-1:0] gnt1;
    logic [DEPTH-1:0] cand1;
    issue_t           pick0;
    issue_t           pick1;

    // lowest index is the oldest entry.
    function automatic logic [DEPTH-1:0] pick_oldest(input logic [DEPTH-1:0] req);
        logic [DEPTH-1:0] gnt;
        logic             found;
        gnt   = '0;
        found = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (req[i] && !found) begin
                gnt[i] = 1'b1;
                found  = 1'b1;
            end
        end
        return gnt;
    endfunction

    function automatic issue_t mux_issue(input logic [DEPTH-1:0] gnt,
                                         input iq_entry_t [DEPTH-1:0] ents);
        issue_t data;
        data = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (gnt[i]) begin
                data = '{rs2: ents[i].rs2, rs1: ents[i].rs1, rob: ents[i].rob};
            end
        end
        return data;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pick
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign gnt0  = pick_oldest(sel.rdy_vec) & {DEPTH{!flush_i}};
    assign cand1 = sel.rdy_vec & ~gnt0 & ~sel.branch_vec;   // branches only go to ALU 0.
    assign gnt1  = pick_oldest(cand1) & {DEPTH{!flush_i}};

    assign sel.grant0 = gnt0;
    assign sel.grant1 = gnt1;

    assign pick0 = mux_issue(gnt0, sel.entries);
    assign pick1 = mux_issue(gnt1, sel.entries);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu0_vld_o <= 1'b0;
            alu1_vld_o <= 1'b0;
        end else begin
            alu0_vld_o <= |gnt0;
            alu1_vld_o <= |gnt1;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        alu0_data_o <= pick0;
        alu1_data_o <= pick1;
    end

endmodule

`default_nettype wire

// ==== verilog/int_issue_queue.sv ====
// Integer issue queue top level.
// Twelve-entry age-ordered queue issuing up to two instructions per cycle.
`timescale 1ns/10ps
`default_nettype none

module int_issue_queue (
    input  wire logic         cpu_clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         disp_vld_i,
    input  wire logic         disp_branch_i,
    input  wire iq_pkg::tag_t disp_rs1_i,
    input  wire iq_pkg::tag_t disp_rs2_i,
    input  wire iq_pkg::tag_t disp_rob_i,
    input  wire logic         disp_rs1_vld_i,
    input  wire logic         disp_rs2_vld_i,
    input  wire logic         disp_rs1_rdy_i,
    input  wire logic         disp_rs2_rdy_i,
    output logic              disp_busy_o,
    input  wire logic         wk0_vld_i,
    input  wire iq_pkg::tag_t wk0_tag_i,
    input  wire logic         wk1_vld_i,
    input  wire iq_pkg::tag_t wk1_tag_i,
    input  wire logic         wk2_vld_i,
    input  wire iq_pkg::tag_t wk2_tag_i,
    input  wire logic         flush_i,
    output logic              alu0_vld_o,
    output iq_pkg::issue_t    alu0_data_o,
    output logic              alu1_vld_o,
    output iq_pkg::issue_t    alu1_data_o
);
    import iq_pkg::*;

    wakeup_vec_t wk_vec;

    iq_alloc_if  alloc_if ();
    iq_select_if sel_if ();

    assign wk_vec[0] = '{vld: wk0_vld_i, tag: wk0_tag_i};
    assign wk_vec[1] = '{vld: wk1_vld_i, tag: wk1_tag_i};
    assign wk_vec[2] = '{vld: wk2_vld_i, tag: wk2_tag_i};

    assign disp_busy_o = alloc_if.busy;

    iq_dispatch iq_dispatch_inst (
        .disp_vld_i     (disp_vld_i),
        .disp_branch_i  (disp_branch_i),
        .disp_rs1_i     (disp_rs1_i),
        .disp_rs2_i     (disp_rs2_i),
        .disp_rob_i     (disp_rob_i),
        .disp_rs1_vld_i (disp_rs1_vld_i),
        .disp_rs2_vld_i (disp_rs2_vld_i),
        .disp_rs1_rdy_i (disp_rs1_rdy_i),
        .disp_rs2_rdy_i (disp_rs2_rdy_i),
        .wk_i           (wk_vec),
        .alloc          (alloc_if.producer)
    );

    iq_entries iq_entries_inst (
        .cpu_clk_i (cpu_clk_i),
        .rst_n_i   (rst_n_i),
        .flush_i   (flush_i),
        .wk_i      (wk_vec),
        .alloc     (alloc_if.queue),
        .sel       (sel_if.queue)
    );

    iq_select iq_select_inst (
        .cpu_clk_i   (cpu_clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .sel         (sel_if.select),
        .alu0_vld_o  (alu0_vld_o),
        .alu0_data_o (alu0_data_o),
        .alu1_vld_o  (alu1_vld_o),
        .alu1_data_o (alu1_data_o)
    );

endmodule

`default_nettype wire

// ==== sim/tb_int_issue_queue.sv ====
// Integer issue queue testbench.
// Replays per-cycle vectors and checks busy and both ALU issue ports.
`timescale 1ns/10ps
`default_nettype none

`include "iq_cfg.svh"

module tb_int_issue_queue;
    import iq_pkg::*;

    localparam realtime CLK_PERIOD = 4.0;
    localparam int      RST_CYCLES = 3;
    localparam int      WD_MARGIN  = 20;
    localparam int      MAX_ROWS   = 64;
    localparam int      NUM_TAGS   = 1 << `IQ_TAG_W;
    localparam string   VEC_FILE   = "sim/iq_vectors.txt";

    logic   cpu_clk;
    logic   rst_n;
    logic   disp_vld;
    logic   disp_branch;
    tag_t   disp_rs1;
    tag_t   disp_rs2;
    tag_t   disp_rob;
    logic   disp_rs1_vld;
    logic   disp_rs2_vld;
    logic   disp_rs1_rdy;
    logic   disp_rs2_rdy;
    logic   disp_busy;
    logic   wk0_vld;
    tag_t   wk0_tag;
    logic   wk1_vld;
    tag_t   wk1_tag;
    logic   wk2_vld;
    tag_t   wk2_tag;
    logic   flush;
    logic   alu0_vld;
    issue_t alu0_data;
    logic   alu1_vld;
    issue_t alu1_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector rows
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    string      row_name [MAX_ROWS];
    int         row_rep  [MAX_ROWS];
    logic       row_vld  [MAX_ROWS];
    logic       row_br   [MAX_ROWS];
    tag_t       row_rs1  [MAX_ROWS];
    tag_t       row_rs2  [MAX_ROWS];
    tag_t       row_rob  [MAX_ROWS];
    logic [1:0] row_sv   [MAX_ROWS];   // rs1 and rs2 in use.
    logic [1:0] row_sr   [MAX_ROWS];   // rs1 and rs2 ready at dispatch.
    logic       row_rnd  [MAX_ROWS];   // rs1 comes from the LCG.
    logic [6:0] row_w0   [MAX_ROWS];
    logic [6:0] row_w1   [MAX_ROWS];
    logic [6:0] row_w2   [MAX_ROWS];
    logic       row_fl   [MAX_ROWS];
    logic       row_busy [MAX_ROWS];
    logic [6:0] row_a0   [MAX_ROWS];
    logic [6:0] row_a1   [MAX_ROWS];

    tag_t rs1_tab [NUM_TAGS];   // sources last dispatched under each rob tag.
    tag_t rs2_tab [NUM_TAGS];

    int          n_rows         = 0;
    int          total_cycles   = 0;
    logic        vectors_loaded = 1'b0;
    logic [31:0] lcg_state      = 32'h2d94_79e9;
    string       cur_test       = "";
    int          test_checks    = 0;
    int          test_errs      = 0;
    int          test_count     = 0;
    int          check_count    = 0;
    int          err_count      = 0;
    logic        pend           = 1'b0;
    logic [6:0]  pend_a0;
    logic [6:0]  pend_a1;

    int_issue_queue int_issue_queue_inst (
        .cpu_clk_i      (cpu_clk),
        .rst_n_i        (rst_n),
        .disp_vld_i     (disp_vld),
        .disp_branch_i  (disp_branch),
        .disp_rs1_i     (disp_rs1),
        .disp_rs2_i     (disp_rs2),
        .disp_rob_i     (disp_rob),
        .disp_rs1_vld_i (disp_rs1_vld),
        .disp_rs2_vld_i (disp_rs2_vld),
        .disp_rs1_rdy_i (disp_rs1_rdy),
        .disp_rs2_rdy_i (disp_rs2_rdy),
        .disp_busy_o    (disp_busy),
        .wk0_vld_i      (wk0_vld),
        .wk0_tag_i      (wk0_tag),
        .wk1_vld_i      (wk1_vld),
        .wk1_tag_i      (wk1_tag),
        .wk2_vld_i      (wk2_vld),
        .wk2_tag_i      (wk2_tag),
        .flush_i        (flush),
        .alu0_vld_o     (alu0_vld),
        .alu0_data_o    (alu0_data),
        .alu1_vld_o     (alu1_vld),
        .alu1_data_o    (alu1_data)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
    end

    function automatic tag_t next_rand_tag();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[29:24];
    endfunction

    // payload of the instruction dispatched under this rob tag.
    function automatic issue_t expected_issue(input tag_t rob);
        issue_t data;
        data.rs2 = rs2_tab[rob];
        data.rs1 = rs1_tab[rob];
        data.rob = rob;
        return data;
    endfunction

    task automatic set_idle();
        disp_vld     = 1'b0;
        disp_branch  = 1'b0;
        disp_rs1     = '0;
        disp_rs2     = '0;
        disp_rob     = '0;
        disp_rs1_vld = 1'b0;
        disp_rs2_vld = 1'b0;
        disp_rs1_rdy = 1'b0;
        disp_rs2_rdy = 1'b0;
        wk0_vld      = 1'b0;
        wk0_tag      = '0;
        wk1_vld      = 1'b0;
        wk1_tag      = '0;
        wk2_vld      = 1'b0;
        wk2_tag      = '0;
        flush        = 1'b0;
    endtask

    task automatic load_vectors();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %s", VEC_FILE);
        end else begin
            while ($fgets(line, fd) > 0 && n_rows < MAX_ROWS) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line,
                        "%s %d %b %b %h %h %h %b %b %b %h %h %h %b %b %h %h",
                        row_name[n_rows], row_rep[n_rows], row_vld[n_rows],
                        row_br[n_rows], row_rs1[n_rows], row_rs2[n_rows],
                        row_rob[n_rows], row_sv[n_rows], row_sr[n_rows],
                        row_rnd[n_rows], row_w0[n_rows], row_w1[n_rows],
                        row_w2[n_rows], row_fl[n_rows], row_busy[n_rows],
                        row_a0[n_rows], row_a1[n_rows]);
                    if (cnt == 17) begin
                        total_cycles += row_rep[n_rows];
                        n_rows++;
                    end else begin
                        $display("a vector line could not be parsed: %s", line);
                        err_count++;
                    end
                end
            end
            $fclose(fd);
        end
        vectors_loaded = 1'b1;
    endtask

    task automatic drive_row(input int r, input int k);
        tag_t rob;
        tag_t rs1;
        rob          = row_rob[r] + tag_t'(k);
        rs1          = row_rnd[r] ? next_rand_tag() : row_rs1[r];
        disp_vld     = row_vld[r];
        disp_branch  = row_br[r];
        disp_rs1     = rs1;
        disp_rs2     = row_rs2[r];
        disp_rob     = rob;
        disp_rs1_vld = row_sv[r][1];
        disp_rs2_vld = row_sv[r][0];
        disp_rs1_rdy = row_sr[r][1];
        disp_rs2_rdy = row_sr[r][0];
        wk0_vld      = row_w0[r][6];
        wk0_tag      = row_w0[r][5:0];
        wk1_vld      = row_w1[r][6];
        wk1_tag      = row_w1[r][5:0];
        wk2_vld      = row_w2[r][6];
        wk2_tag      = row_w2[r][5:0];
        flush        = row_fl[r];
        if (row_vld[r]) begin
            rs1_tab[rob] = rs1;
            rs2_tab[rob] = row_rs2[r];
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        test_checks++;
        assert (act == exp) else begin
            $display("ERR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_issue(input string port, input logic [6:0] exp,
                               input logic act_vld, input issue_t act_data);
        issue_t exp_data;
        exp_data = expected_issue(exp[5:0]);
        check_value({port, " valid"}, 32'(exp[6]), 32'(act_vld));
        if (exp[6]) begin
            check_value({port, " data"}, {14'b0, exp_data}, {14'b0, act_data});
        end
    endtask

    task automatic check_pending();
        if (pend) begin
            check_issue("alu0", pend_a0, alu0_vld, alu0_data);
            check_issue("alu1", pend_a1, alu1_vld, alu1_data);
        end
    endtask

    task automatic close_test();
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
        test_count++;
        check_count += test_checks;
        err_count   += test_errs;
        test_checks = 0;
        test_errs   = 0;
    endtask

    initial begin
        set_idle();
        rst_n = 1'b0;
        load_vectors();
        if (n_rows == 0) begin
            $display("no usable vectors were found, nothing was tested");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            repeat (RST_CYCLES) @(posedge cpu_clk);
            #0.5;
            rst_n    = 1'b1;
            cur_test = row_name[0];
            for (int r = 0; r < n_rows; r++) begin
                for (int k = 0; k < row_rep[r]; k++) begin
                    @(posedge cpu_clk);
                    #0.5;
                    check_pending();                 // results of the previous cycle.
                    if (row_name[r] != cur_test) begin
                        close_test();
                        cur_test = row_name[r];
                    end
                    drive_row(r, k);
                    #3.0;
                    check_value("busy", 32'(row_busy[r]), 32'(disp_busy));
                    pend    = 1'b1;
                    pend_a0 = row_a0[r];
                    pend_a1 = row_a1[r];
                end
            end
            @(posedge cpu_clk);
            #0.5;
            check_pending();
            close_test();
            $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
            if (err_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // watchdog sized from the vector cycle count.
    initial begin
        wait (vectors_loaded);
        #((total_cycles + RST_CYCLES + WD_MARGIN) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles",
                 total_cycles + RST_CYCLES + WD_MARGIN);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/iq_vectors.txt ====
# test    n v b rs1 rs2 rob sv sr r w0 w1 w2 f y a0 a1
# n repeats a row with rob +1 each time, y is busy, w0-w2 a0 a1 are hex {valid, tag}
reset     1 0 0 00  00  00  00 00 0 00 00 00 0 0 00 00
ready     1 1 0 02  03  01  11 11 0 00 00 00 0 0 00 00
ready     1 0 0 00  00  00  00 00 0 00 00 00 0 0 41 00
ready     1 0 0 00  00  00  00 00 0 00 00 00 0 0 00 00
wakeup    1 1 0 0a  0b  02  11 01 0 00 00 00 0 0 00 00
wakeup    1 1 0 0c  0d  03  11 10 0 00 4a 00 0 0 00 00
wakeup    1 1 0 0e  0f  04  11 01 0 4e 00 4d 0 0 42 00
wakeup    1 0 0 00  00  00  00 00 0 00 00 00 0 0 43 44
wakeup    1 0 0 00  00  00  00 00 0 00 00 00 0 0 00 00
dual      2 1 0 24  01  05  10 00 0 00 00 00 0 0 00 00
dual      1 1 0 24  02  07  10 00 0 00 00 00 0 0 00 00
dual      1 1 1 24  03  08  10 00 0 00 00 00 0 0 00 00
dual      1 1 0 24  04  09  10 00 0 00 00 00 0 0 00 00
dual      1 1 1 24  05  0a  10 00 0 64 00 00 0 0 00 00
dual      1 0 0 00  00  00  00 00 0 00 00 00 0 0 45 46
dual      1 0 0 00  00  00  00 00 0 00 00 00 0 0 47 49
dual      1 0 0 00  00  00  00 00 0 00 00 00 0 0 48 00
dual      1 0 0 00  00  00  00 00 0 00 00 00 0 0 4a 00
dual      1 0 0 00  00  00  00 00 0 00 00 00 0 0 00 00
fill     12 1 0 00  3f  10  11 10 1 00 00 00 0 0 00 00
fill      1 1 0 30  31  1c  11 11 0 00 00 00 0 1 00 00
fill      1 1 0 30  31  1c  11 11 0 7f 00 00 0 1 00 00
fill      1 1 0 30  31  1c  11 11 0 00 00 00 0 1 50 51
fill      1 1 0 30  31  1c  11 11 0 00 00 00 0 0 52 53
fill      1 0 0 00  00  00  00 00 0 00 00 00 0 0 54 55
fill      1 0 0 00  00  00  00 00 0 00 00 00 0 0 56 57
fill      1 0 0 00  00  00  00 00 0 00 00 00 0 0 58 59
fill      1 0 0 00  00  00  00 00 0 00 00 00 0 0 5a 5b
fill      1 0 0 00  00  00  00 00 0 00 00 00 0 0 5c 00
fill      1 0 0 00  00  00  00 00 0 00 00 00 0 0 00 00
flush     1 1 0 26  07  23  11 01 0 00 00 00 0 0 00 00
flush     1 1 0 08  09  20  11 11 0 00 00 00 0 0 00 00
flush     1 1 0 0a  0b  21  11 11 0 00 00 00 1 0 00 00
flush     1 0 0 00  00  00  00 00 0 66 00 00 0 0 00 00
flush     1 1 0 0c  0d  22  11 11 0 00 00 00 0 0 00 00
flush     1 0 0 00  00  00  00 00 0 00 00 00 0 0 62 00
flush     1 0 0 00  00  00  00 00 0 00 00 00 0 0 00 00

// ==== int_issue_queue.f ====
+incdir+include
verilog/iq_pkg.sv
verilog/iq_if.sv
verilog/iq_dispatch.sv
verilog/iq_entries.sv
verilog/iq_select.sv
verilog/int_issue_queue.sv
sim/tb_int_issue_queue.sv

// ==== Makefile ====
# Verilator build and run for the integer issue queue testbench.

TOP       ?= tb_int_issue_queue
SEED      ?= 1
LOG       ?= sim.log
FILELIST  ?= int_issue_queue.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: TOP SEED LOG FILELIST BUILD_DIR VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q "^NO ERRORS" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
